// ==== build.f ====
+incdir+source
source/rename_pkg.sv
source/free_list.sv
source/map_table.sv
source/rename_stage.sv
test/rename_checker.sv
test/tb_rename.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the rename testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f build.f --top-module tb_rename -Mdir obj_dir -o sim_rename
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_rename > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# the log decides the result
if grep -q "tests failed" "$log"; then
	exit 1
fi
exit 0

// ==== source/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

// circular fifo of physical registers that are not mapped to anything
// head supplies the register for the next dispatch, tail takes retired registers
module free_list (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  dispatch,   // rename request from decode
	input  wire logic                  retire_en,  // retire strobe, frees retire_reg
	input  wire rename_pkg::phys_reg_t retire_reg, // previous mapping of the retired dest
	output logic                       grant,      // dispatch accepted this cycle
	output rename_pkg::phys_reg_t      new_reg,    // register handed out on grant
	output rename_pkg::free_count_t    free_count  // number of entries in the list
);

	localparam int DEPTH = `RENAME_FREE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	rename_pkg::phys_reg_t fifo_mem [DEPTH]; // register numbers waiting to be reused

	logic [PTR_W-1:0] head; // next entry to hand out
	logic [PTR_W-1:0] tail; // next slot for a retired register

	logic empty;
	logic full;
	logic push;
	logic pop;

	assign empty = (free_count == '0);
	assign full  = (free_count == rename_pkg::free_count_t'(DEPTH));

	// the only back-pressure in the rename stage
	assign grant = dispatch && !empty;

	assign pop  = grant;
	assign push = retire_en; // the rob never retires more than it renamed

	assign new_reg = fifo_mem[head]; // head is visible in the same cycle as dispatch

	// pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			head       <= '0;
			tail       <= '0; // list starts full so tail wraps onto head
			free_count <= rename_pkg::free_count_t'(DEPTH);
		end else begin
			if (pop) begin
				head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
			end
			if (push) begin
				tail <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
			end
			case ({push, pop})
				2'b10:   free_count <= free_count + 1'b1;
				2'b01:   free_count <= free_count - 1'b1;
				default: free_count <= free_count; // idle, or push and pop cancel
			endcase
		end
	end

	// storage, reset hands out the registers above the identity map
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				fifo_mem[i] <= rename_pkg::phys_reg_t'(`RENAME_NUM_ARCH + i); // p32..p63
			end
		end else if (push) begin
			fifo_mem[tail] <= retire_reg;
		end
	end

	// more registers than exist can never be free at once
	a_no_push_full: assert property (
		@(posedge clock) disable iff (reset)
		retire_en |-> !full
	) else $error("free_list: retire push while list is full");

	// a granted dispatch must always find a register at head
	// head meeting tail with the list not full means nothing is left
	a_no_grant_empty: assert property (
		@(posedge clock) disable iff (reset)
		grant |-> (full || (head != tail))
	) else $error("free_list: grant with no register between head and tail");

endmodule

`default_nettype wire

// ==== source/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

// architectural to physical map with ready bits
// cdb broadcasts wake every row holding the broadcast register
module map_table (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  grant,   // dispatch accepted, remap dest
	input  wire rename_pkg::arch_reg_t src_a,   // first source operand
	input  wire rename_pkg::arch_reg_t src_b,   // second source operand
	input  wire rename_pkg::arch_reg_t dest,    // destination operand
	input  wire rename_pkg::phys_reg_t new_reg, // head of the free list
	input  wire logic                  cdb_en,  // result broadcast valid
	input  wire rename_pkg::phys_reg_t cdb_reg, // register whose value is now ready
	output rename_pkg::phys_tag_t      tag_a,   // source a tag, cdb bypassed
	output rename_pkg::phys_tag_t      tag_b,   // source b tag, cdb bypassed
	output rename_pkg::phys_tag_t      tag_old, // dest mapping before this dispatch
	output rename_pkg::phys_tag_t      tag_new  // dest mapping after this dispatch
);

	localparam int NUM_ARCH = `RENAME_NUM_ARCH;
	localparam int REG_W    = $bits(rename_pkg::phys_reg_t);
	localparam int RDY      = REG_W; // ready sits just above the register number

	rename_pkg::phys_tag_t map_rows [NUM_ARCH];

	rename_pkg::phys_tag_t row_a; // raw row reads before bypass
	rename_pkg::phys_tag_t row_b;

	logic [`RENAME_NUM_PHYS-1:0] phys_seen; // occupancy for the uniqueness check
	logic                        dup_found;

	assign row_a = map_rows[src_a];
	assign row_b = map_rows[src_b];

	// source lookup
	// a producer broadcasting this cycle already counts as ready
	always_comb begin
		tag_a = row_a;
		tag_b = row_b;
		if (cdb_en && (row_a[REG_W-1:0] == cdb_reg)) begin
			tag_a[RDY] = 1'b1;
		end
		if (cdb_en && (row_b[REG_W-1:0] == cdb_reg)) begin
			tag_b[RDY] = 1'b1;
		end
	end

	assign tag_old = map_rows[dest];       // handed to the rob, freed at retire
	assign tag_new = {1'b0, new_reg};      // fresh register waits for its producer

	// table update
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH; i++) begin
				map_rows[i] <= {1'b1, rename_pkg::phys_reg_t'(i)}; // ri -> pi, ready
			end
		end else begin
			// cam over every row
			for (int i = 0; i < NUM_ARCH; i++) begin
				if (cdb_en && (map_rows[i][REG_W-1:0] == cdb_reg)) begin
					map_rows[i][RDY] <= 1'b1;
				end
			end
			// later assignment, so dispatch beats a cdb hit on the same row
			if (grant) begin
				map_rows[dest] <= {1'b0, new_reg};
			end
		end
	end

	// scan for a physical register mapped twice
	always_comb begin
		phys_seen = '0;
		dup_found = 1'b0;
		for (int i = 0; i < NUM_ARCH; i++) begin
			if (phys_seen[map_rows[i][REG_W-1:0]]) begin
				dup_found = 1'b1;
			end
			phys_seen[map_rows[i][REG_W-1:0]] = 1'b1;
		end
	end

	// the free list must never hand out a register that is still mapped
	a_unique_map: assert property (
		@(posedge clock) disable iff (reset)
		!dup_found
	) else $error("map_table: physical register mapped by two rows");

endmodule

`default_nettype wire

// ==== source/rename_cfg.svh ====
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// architectural register file size, r0..r31
`define RENAME_NUM_ARCH 32

// physical register file size
`define RENAME_NUM_PHYS 64

// free list only ever holds the registers not currently mapped
`define RENAME_FREE_DEPTH (`RENAME_NUM_PHYS - `RENAME_NUM_ARCH)

`endif

// ==== source/rename_pkg.sv ====
`default_nettype none

`include "rename_cfg.svh"

package rename_pkg;

	// architectural register index from decode
	typedef logic [$clog2(`RENAME_NUM_ARCH)-1:0] arch_reg_t;

	// physical register number
	typedef logic [$clog2(`RENAME_NUM_PHYS)-1:0] phys_reg_t;

	// rename tag, msb is the ready bit, low bits the physical register
	typedef logic [$clog2(`RENAME_NUM_PHYS):0] phys_tag_t;

	// occupancy of the free list, one bit wider so a full list fits
	typedef logic [$clog2(`RENAME_FREE_DEPTH):0] free_count_t;

endpackage

`default_nettype wire

// ==== source/rename_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// single-issue register rename
// free list supplies the new register, map table does lookup and remap
module rename_stage (
	input  wire logic                  clock,
	input  wire logic                  reset,

	// dispatch from decode
	input  wire logic                  dispatch,
	input  wire rename_pkg::arch_reg_t src_a,
	input  wire rename_pkg::arch_reg_t src_b,
	input  wire rename_pkg::arch_reg_t dest,

	// result broadcast
	input  wire logic                  cdb_en,
	input  wire rename_pkg::phys_reg_t cdb_reg,

	// retire from the rob, returns the old dest mapping
	input  wire logic                  retire_en,
	input  wire rename_pkg::phys_reg_t retire_reg,

	output logic                       grant,     // low when the free list is empty
	output rename_pkg::phys_tag_t      tag_a,
	output rename_pkg::phys_tag_t      tag_b,
	output rename_pkg::phys_tag_t      tag_old,
	output rename_pkg::phys_tag_t      tag_new,
	output rename_pkg::free_count_t    free_count
);

	rename_pkg::phys_reg_t new_reg; // free list head into the map

	free_list u_free_list (
		.clock      (clock),
		.reset      (reset),
		.dispatch   (dispatch),
		.retire_en  (retire_en),
		.retire_reg (retire_reg),
		.grant      (grant),
		.new_reg    (new_reg),
		.free_count (free_count)
	);

	// grant doubles as the map write enable
	map_table u_map_table (
		.clock   (clock),
		.reset   (reset),
		.grant   (grant),
		.src_a   (src_a),
		.src_b   (src_b),
		.dest    (dest),
		.new_reg (new_reg),
		.cdb_en  (cdb_en),
		.cdb_reg (cdb_reg),
		.tag_a   (tag_a),
		.tag_b   (tag_b),
		.tag_old (tag_old),
		.tag_new (tag_new)
	);

endmodule

`default_nettype wire

// ==== test/rename_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

// reference model of the rename map and free list
// samples at the falling edge, when the dut outputs are stable
module rename_checker (
	input  wire logic                  clock,
	input  wire logic                  reset,
	input  wire logic                  dispatch,
	input  wire rename_pkg::arch_reg_t src_a,
	input  wire rename_pkg::arch_reg_t src_b,
	input  wire rename_pkg::arch_reg_t dest,
	input  wire logic                  cdb_en,
	input  wire rename_pkg::phys_reg_t cdb_reg,
	input  wire logic                  retire_en,
	input  wire rename_pkg::phys_reg_t retire_reg,
	input  wire logic                  grant,
	input  wire rename_pkg::phys_tag_t tag_a,
	input  wire rename_pkg::phys_tag_t tag_b,
	input  wire rename_pkg::phys_tag_t tag_old,
	input  wire rename_pkg::phys_tag_t tag_new,
	input  wire rename_pkg::free_count_t free_count,
	input  wire logic                  row_valid,  // a table row is on the inputs
	input  wire logic                  row_chk,    // the row carries an expected grant
	input  wire logic                  row_grant,
	output logic [31:0]                errors,
	output logic [31:0]                rows_seen,
	output logic                       pend_avail, // an old mapping is waiting to retire
	output rename_pkg::phys_reg_t      pend_head   // oldest such mapping
);

	localparam int NUM_ARCH = `RENAME_NUM_ARCH;
	localparam int DEPTH    = `RENAME_FREE_DEPTH;
	localparam int REG_W    = $bits(rename_pkg::phys_reg_t);

	rename_pkg::phys_tag_t model_map [NUM_ARCH];
	rename_pkg::phys_reg_t free_q[$]; // free registers, head first
	rename_pkg::phys_reg_t pend_q[$]; // old mappings in dispatch order, like a rob

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors = errors + 1;
			$display("MISMATCH %s: got %0h expected %0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_error(input string what);
		errors = errors + 1;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	task automatic compare_outputs();
		logic                  e_grant;
		rename_pkg::phys_tag_t e_a;
		rename_pkg::phys_tag_t e_b;
		e_grant = dispatch && (free_q.size() != 0); // refused only when empty
		e_a = model_map[src_a];
		e_b = model_map[src_b];
		if (cdb_en && (e_a[REG_W-1:0] == cdb_reg)) e_a[REG_W] = 1'b1; // same-cycle bypass
		if (cdb_en && (e_b[REG_W-1:0] == cdb_reg)) e_b[REG_W] = 1'b1;
		check_val("grant", 32'(grant), 32'(e_grant));
		if (row_valid && row_chk) begin
			check_val("grant (table row)", 32'(grant), 32'(row_grant));
		end
		check_val("tag_a", 32'(tag_a), 32'(e_a));
		check_val("tag_b", 32'(tag_b), 32'(e_b));
		check_val("tag_old", 32'(tag_old), 32'(model_map[dest])); // raw row, no bypass
		// head of an empty list is stale, nothing to compare
		if (free_q.size() != 0) begin
			check_val("tag_new", 32'(tag_new), 32'({1'b0, free_q[0]}));
		end
		check_val("free_count", 32'(free_count), 32'(free_q.size()));
	endtask

	// state as it stands after the coming rising edge
	task automatic update_model();
		logic                  granted;
		rename_pkg::phys_reg_t head_reg;
		granted = dispatch && (free_q.size() != 0);
		if (cdb_en) begin
			for (int i = 0; i < NUM_ARCH; i++) begin
				if (model_map[i][REG_W-1:0] == cdb_reg) model_map[i][REG_W] = 1'b1;
			end
		end
		if (granted) begin
			pend_q.push_back(model_map[dest][REG_W-1:0]);
			head_reg = free_q.pop_front();
			model_map[dest] = {1'b0, head_reg}; // written after the cam, so dispatch wins
		end
		if (retire_en) begin
			if (pend_q.size() == 0) begin
				report_error("retire with no outstanding old mapping");
			end else if (retire_reg != pend_q[0]) begin
				report_error("retire of a register that is not the oldest old mapping");
			end else begin
				void'(pend_q.pop_front());
			end
			if (free_q.size() >= DEPTH) report_error("retire into a full free list");
			else free_q.push_back(retire_reg);
		end
		if (row_valid) rows_seen = rows_seen + 1;
	endtask

	always @(negedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH; i++) begin
				model_map[i] = {1'b1, rename_pkg::phys_reg_t'(i)}; // identity, all ready
			end
			free_q.delete();
			for (int i = 0; i < DEPTH; i++) begin
				free_q.push_back(rename_pkg::phys_reg_t'(NUM_ARCH + i));
			end
			pend_q.delete();
			errors    = '0;
			rows_seen = '0;
		end else begin
			compare_outputs();
			update_model();
		end
		pend_avail = (pend_q.size() != 0);
		pend_head  = (pend_q.size() != 0) ? pend_q[0] : '0;
	end

endmodule

`default_nettype wire

// ==== test/tb_rename.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_cfg.svh"

module tb_rename;

	localparam int MODE_DIR = 0; // fields straight from the row
	localparam int MODE_RND = 1; // random src_a, src_b, dest
	localparam int MODE_MIX = 2; // random strobes as well

	typedef struct packed {
		logic [15:0]           count; // cycles this row is applied
		logic [1:0]            mode;
		logic                  disp;
		rename_pkg::arch_reg_t sa;
		rename_pkg::arch_reg_t sb;
		rename_pkg::arch_reg_t d;
		logic                  cdb;
		rename_pkg::phys_reg_t creg;
		logic                  ret;   // retire the oldest old mapping
		logic                  chk;
		logic                  gnt;   // expected grant
	} row_t;

	logic                    clock;
	logic                    reset;
	logic                    dispatch;
	rename_pkg::arch_reg_t   src_a;
	rename_pkg::arch_reg_t   src_b;
	rename_pkg::arch_reg_t   dest;
	logic                    cdb_en;
	rename_pkg::phys_reg_t   cdb_reg;
	logic                    retire_en;
	rename_pkg::phys_reg_t   retire_reg;
	logic                    grant;
	rename_pkg::phys_tag_t   tag_a;
	rename_pkg::phys_tag_t   tag_b;
	rename_pkg::phys_tag_t   tag_old;
	rename_pkg::phys_tag_t   tag_new;
	rename_pkg::free_count_t free_count;
	logic                    row_valid;
	logic                    row_chk;
	logic                    row_grant;
	logic [31:0]             chk_errors;
	logic [31:0]             chk_rows_seen;
	logic                    pend_avail;
	rename_pkg::phys_reg_t   pend_head;

	row_t        rows[$];
	int unsigned applied;   // cycles driven from the table
	int unsigned tb_errors; // timeouts
	logic        ok;

	rename_stage dut (
		.clock(clock), .reset(reset), .dispatch(dispatch), .src_a(src_a), .src_b(src_b),
		.dest(dest), .cdb_en(cdb_en), .cdb_reg(cdb_reg), .retire_en(retire_en),
		.retire_reg(retire_reg), .grant(grant), .tag_a(tag_a), .tag_b(tag_b),
		.tag_old(tag_old), .tag_new(tag_new), .free_count(free_count)
	);

	rename_checker chk (
		.clock(clock), .reset(reset), .dispatch(dispatch), .src_a(src_a), .src_b(src_b),
		.dest(dest), .cdb_en(cdb_en), .cdb_reg(cdb_reg), .retire_en(retire_en),
		.retire_reg(retire_reg), .grant(grant), .tag_a(tag_a), .tag_b(tag_b),
		.tag_old(tag_old), .tag_new(tag_new), .free_count(free_count),
		.row_valid(row_valid), .row_chk(row_chk), .row_grant(row_grant),
		.errors(chk_errors), .rows_seen(chk_rows_seen),
		.pend_avail(pend_avail), .pend_head(pend_head)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic rename_pkg::arch_reg_t rand_arch();
		return rename_pkg::arch_reg_t'($urandom());
	endfunction

	function automatic rename_pkg::phys_reg_t rand_phys();
		return rename_pkg::phys_reg_t'($urandom());
	endfunction

	task automatic add_row(input int count, input int mode, input int disp, input int sa,
		input int sb, input int d, input int cdb, input int creg, input int ret,
		input int chk_en, input int gnt);
		row_t r;
		r.count = 16'(count);
		r.mode  = 2'(mode);
		r.disp  = (disp != 0);
		r.sa    = rename_pkg::arch_reg_t'(sa);
		r.sb    = rename_pkg::arch_reg_t'(sb);
		r.d     = rename_pkg::arch_reg_t'(d);
		r.cdb   = (cdb != 0);
		r.creg  = rename_pkg::phys_reg_t'(creg);
		r.ret   = (ret != 0);
		r.chk   = (chk_en != 0);
		r.gnt   = (gnt != 0);
		rows.push_back(r);
	endtask

	task automatic apply_row(input row_t r);
		logic do_ret;
		for (int k = 0; k < int'(r.count); k++) begin
			@(posedge clock);
			row_valid <= 1'b1;
			row_chk   <= r.chk;
			row_grant <= r.gnt;
			if (int'(r.mode) == MODE_DIR) begin
				src_a <= r.sa;
				src_b <= r.sb;
				dest  <= r.d;
			end else begin
				src_a <= rand_arch();
				src_b <= rand_arch();
				dest  <= rand_arch();
			end
			if (int'(r.mode) == MODE_MIX) begin
				dispatch <= (($urandom() % 4) != 0);
				cdb_en   <= (($urandom() % 2) != 0);
				cdb_reg  <= rand_phys();
				do_ret = pend_avail && (($urandom() % 2) != 0); // only recorded old mappings
			end else begin
				dispatch <= r.disp;
				cdb_en   <= r.cdb;
				cdb_reg  <= r.creg;
				do_ret = r.ret;
			end
			retire_en  <= do_ret;
			retire_reg <= pend_head;
			applied++;
		end
	endtask

	task automatic wait_reset_done(output logic done);
		done = 1'b0;
		for (int i = 0; i < 20 && !done; i++) begin
			@(negedge clock);
			if (!reset && (free_count == rename_pkg::free_count_t'(`RENAME_FREE_DEPTH))) begin
				done = 1'b1;
			end
		end
		if (!done) begin
			tb_errors++;
			$display("ERROR: free list did not come out of reset full");
		end
	endtask

	task automatic wait_checker_drain(output logic done);
		done = 1'b0;
		for (int i = 0; i < 20 && !done; i++) begin
			@(negedge clock);
			if (chk_rows_seen == 32'(applied)) done = 1'b1;
		end
		if (!done) begin
			tb_errors++;
			$display("ERROR: checker saw %0d of %0d table cycles", chk_rows_seen, applied);
		end
	endtask

	task automatic finish_run();
		$display("closing report: %0d checker errors, %0d testbench errors", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	endtask

	initial begin
		void'($urandom(58));
		applied = 0;
		tb_errors = 0;
		reset = 1'b1;
		dispatch = 1'b0;
		src_a = '0;
		src_b = '0;
		dest = '0;
		cdb_en = 1'b0;
		cdb_reg = '0;
		retire_en = 1'b0;
		retire_reg = '0;
		row_valid = 1'b0;
		row_chk = 1'b0;
		row_grant = 1'b0;

		// cnt mode disp sa sb d cdb creg ret chk gnt
		add_row(1, MODE_DIR, 1, 1, 2, 3, 0, 0, 0, 1, 1);  // r3 -> p32
		add_row(1, MODE_DIR, 1, 3, 4, 5, 0, 0, 0, 1, 1);  // src r3 sees p32 not ready
		add_row(1, MODE_DIR, 1, 3, 5, 6, 1, 32, 0, 1, 1); // p32 bypassed to ready
		add_row(1, MODE_DIR, 1, 3, 0, 7, 0, 0, 0, 1, 1);  // p32 ready from the table
		add_row(1, MODE_DIR, 1, 5, 5, 5, 1, 33, 0, 1, 1); // cdb and remap on r5
		add_row(1, MODE_DIR, 1, 5, 6, 9, 0, 0, 0, 1, 1);  // r5 holds p36, not ready
		add_row(1, MODE_DIR, 0, 0, 0, 0, 0, 0, 0, 1, 0);
		add_row(3, MODE_DIR, 0, 0, 0, 0, 0, 0, 1, 1, 0);  // retire p3, p5, p6
		add_row(26, MODE_RND, 1, 0, 0, 0, 0, 0, 0, 1, 1); // remaining originals p38..p63
		add_row(3, MODE_RND, 1, 0, 0, 0, 0, 0, 0, 1, 1);  // then the retired ones in order
		add_row(2, MODE_RND, 1, 0, 0, 0, 0, 0, 0, 1, 0);  // empty list refuses
		add_row(1, MODE_DIR, 0, 0, 0, 0, 0, 0, 0, 1, 0);
		add_row(1, MODE_DIR, 0, 0, 0, 0, 0, 0, 1, 1, 0);  // one register back
		add_row(2, MODE_RND, 1, 0, 0, 0, 0, 0, 1, 1, 1);  // push and pop, count holds at 1
		add_row(600, MODE_MIX, 0, 0, 0, 0, 0, 0, 0, 0, 0);

		repeat (10) @(posedge clock);
		reset <= 1'b0;
		wait_reset_done(ok);
		if (ok) begin
			foreach (rows[i]) apply_row(rows[i]);
			@(posedge clock);
			row_valid <= 1'b0;
			row_chk   <= 1'b0;
			dispatch  <= 1'b0;
			cdb_en    <= 1'b0;
			retire_en <= 1'b0;
			wait_checker_drain(ok);
		end
		finish_run();
	end

endmodule

`default_nettype wire
